//--- dramAxiBridge.f
hdl/axiPkg.sv
hdl/dramPkg.sv
hdl/requestCapture.sv
hdl/dramSequencer.sv
hdl/responseOut.sv
hdl/dramAxiBridge.sv
bench/dramModel.sv
bench/tbDramAxiBridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbDramAxiBridge
FILELIST  ?= dramAxiBridge.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/tbDramAxiBridge.sv
`timescale 1ns/10ps

module tbDramAxiBridge;

	typedef enum logic [1:0] {opRead, opWrite, opBoth} op_t;

	typedef struct packed {
		op_t         op;
		logic [7:0]  id;
		logic [31:0] addr;
		logic [7:0]  len;
		logic [31:0] data;
		logic [3:0]  strb;
		int          expAct;  // Activates this entry adds
	} entry_t;

	localparam int numEntries = 10;

	// opBoth reads first, then writes with id plus one
	entry_t stim [numEntries] = '{
		'{opWrite, 8'h11, 32'h0000_1010, 8'd0,  32'hcafe_f00d, 4'hf, 1},
		'{opRead,  8'h21, 32'h0000_1010, 8'd0,  32'h0,         4'h0, 0},
		'{opRead,  8'h22, 32'h0000_1100, 8'd3,  32'h0,         4'h0, 0},
		'{opWrite, 8'h12, 32'h0000_1104, 8'd0,  32'h1234_5678, 4'h5, 0},
		'{opRead,  8'h23, 32'h0000_1104, 8'd0,  32'h0,         4'h0, 0},
		'{opRead,  8'h24, 32'h0000_5000, 8'd1,  32'h0,         4'h0, 1},
		'{opRead,  8'h25, 32'h0000_5ff8, 8'd3,  32'h0,         4'h0, 1},  // Into row 6
		'{opBoth,  8'h26, 32'h0000_6008, 8'd0,  32'h0bad_beef, 4'hc, 0},
		'{opRead,  8'h28, 32'h0000_6008, 8'd0,  32'h0,         4'h0, 0},
		'{opRead,  8'h29, 32'h0030_0000, 8'd15, 32'h0,         4'h0, 1}
	};

	logic        ACLK = 1'b0;
	logic        ARESETn;
	logic [7:0]  ARID, AWID, RID, BID, ARLEN;
	logic [31:0] ARADDR, AWADDR, WDATA, RDATA, Q, D;
	logic [3:0]  WSTRB, WEn;
	logic [1:0]  RRESP, BRESP;
	logic [10:0] A;
	logic        ARVALID, AWVALID, WVALID, RREADY, BREADY, VALID;
	logic        ARREADY, AWREADY, WREADY, RLAST, RVALID, BVALID, CSn, RASn, CASn;
	int          actCount;
	int          actBefore;
	time         arSeen, awSeen;
	logic [31:0] refMem [int];

	dramAxiBridge i_dut (.*);
	dramModel i_model (.*);

	always #5 ACLK = ~ACLK;

	function automatic logic [31:0] fillWord(int k);
		return 32'(k) * 32'h9e37_79b1 ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] expectWord(logic [31:0] addr);
		int k;
		k = int'(addr[22:2]);
		return refMem.exists(k) ? refMem[k] : fillWord(k);
	endfunction

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "Check on %s did not match", name);
		end
	endtask

	// Inputs change 1 ns after the edge, outputs are sampled there too
	task automatic tick();
		@(posedge ACLK);
		#1;
	endtask

	task automatic readBurst(logic [7:0] id, logic [31:0] addr, logic [7:0] len);
		int beat;
		beat    = 0;
		ARID    = id;
		ARADDR  = addr;
		ARLEN   = len;
		ARVALID = 1'b1;
		while (!ARREADY) tick();
		arSeen = $time;
		tick();
		ARVALID = 1'b0;
		while (beat <= int'(len)) begin
			RREADY = $urandom_range(0, 2) != 0;  // Stalls about a third of the cycles
			if (RVALID && RREADY) begin
				checkValue("RDATA", RDATA, expectWord(addr + 32'(4 * beat)));
				checkValue("RID", 32'(RID), 32'(id));
				checkValue("RRESP", 32'(RRESP), 32'd0);
				checkValue("RLAST", 32'(RLAST), 32'(beat == int'(len)));
				beat++;
			end
			tick();
		end
		RREADY = 1'b0;
	endtask

	task automatic writeSingle(logic [7:0] id, logic [31:0] addr, logic [31:0] data,
			logic [3:0] strb);
		logic        bSeen;
		logic        done;
		logic [31:0] word;
		bSeen   = 1'b0;
		done    = 1'b0;
		AWID    = id;
		AWADDR  = addr;
		AWVALID = 1'b1;
		WDATA   = data;
		WSTRB   = strb;
		WVALID  = 1'b1;
		while (!AWREADY) tick();
		awSeen = $time;
		tick();
		AWVALID = 1'b0;
		while (!WREADY) tick();
		tick();
		WVALID = 1'b0;
		while (!done) begin
			if (bSeen) checkValue("BVALID", 32'(BVALID), 32'd1);
			BREADY = bSeen && ($urandom_range(0, 1) == 1);  // First BVALID cycle always stalls
			if (BVALID && BREADY) begin
				checkValue("BID", 32'(BID), 32'(id));
				checkValue("BRESP", 32'(BRESP), 32'd0);
				done = 1'b1;
			end
			bSeen = bSeen || BVALID;
			tick();
		end
		BREADY = 1'b0;
		word = expectWord(addr);
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) word[8*i +: 8] = data[8*i +: 8];
		end
		refMem[int'(addr[22:2])] = word;
	endtask

	initial begin
		repeat (numEntries * 400) @(posedge ACLK);
		$display("Run timed out before all table entries finished");
		$display("TESTS FAILED");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		void'($urandom(30059));
		ARESETn = 1'b0;
		ARID    = '0;
		ARADDR  = '0;
		ARLEN   = '0;
		ARVALID = 1'b0;
		AWID    = '0;
		AWADDR  = '0;
		AWVALID = 1'b0;
		WDATA   = '0;
		WSTRB   = '0;
		WVALID  = 1'b0;
		RREADY  = 1'b0;
		BREADY  = 1'b0;
		repeat (16) @(posedge ACLK);
		#1;
		// Handshakes idle, DRAM strobes high
		checkValue("reset outputs", 32'({ARREADY, AWREADY, WREADY, RVALID, RLAST, BVALID,
			CSn, RASn, CASn, WEn}), 32'h7f);
		ARESETn = 1'b1;
		tick();

		for (int n = 0; n < numEntries; n++) begin
			actBefore = actCount;
			case (stim[n].op)
				opRead: readBurst(stim[n].id, stim[n].addr, stim[n].len);
				opWrite: writeSingle(stim[n].id, stim[n].addr, stim[n].data, stim[n].strb);
				default: begin
					fork
						readBurst(stim[n].id, stim[n].addr, stim[n].len);
						writeSingle(stim[n].id + 8'h1, stim[n].addr, stim[n].data, stim[n].strb);
					join
					checkValue("AWREADY after ARREADY", 32'(awSeen > arSeen), 32'd1);
				end
			endcase
			checkValue("activate count", actCount - actBefore, stim[n].expAct);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- bench/dramModel.sv
`timescale 1ns/10ps

module dramModel (
	input  logic        ACLK,
	input  logic        CSn,
	input  logic        RASn,
	input  logic        CASn,
	input  logic [3:0]  WEn,
	input  logic [10:0] A,
	input  logic [31:0] D,
	output logic [31:0] Q,
	output logic        VALID,
	output int          actCount
);

	logic [31:0] mem [int];
	logic [31:0] word;
	logic [31:0] qNext;
	logic [10:0] row;
	logic        readPend = 1'b0;
	int          acts = 0;
	int          key;

	// Unwritten words read back as a pattern of their address
	function automatic logic [31:0] fillWord(int k);
		return 32'(k) * 32'h9e37_79b1 ^ 32'h5a5a_c3c3;
	endfunction

	assign key      = int'({row, A[9:0]});
	assign actCount = acts;

	always @(posedge ACLK) begin
		VALID    <= readPend;  // Word appears two cycles after the read
		Q        <= qNext;
		readPend <= 1'b0;
		if (!CSn && !RASn && CASn && WEn == 4'hf) begin
			row  <= A;
			acts <= acts + 1;
		end else if (!CSn && RASn && !CASn) begin
			word = mem.exists(key) ? mem[key] : fillWord(key);
			if (WEn == 4'hf) begin
				qNext    <= word;
				readPend <= 1'b1;
			end else begin
				for (int i = 0; i < 4; i++) begin
					if (!WEn[i]) word[8*i +: 8] = D[8*i +: 8];
				end
				mem[key] = word;
			end
		end
	end

endmodule

//--- hdl/dramAxiBridge.sv
`timescale 1ns/10ps

module dramAxiBridge (
	input  logic                             ACLK,
	input  logic                             ARESETn,
	input  logic [axiPkg::idWidth-1:0]       ARID,
	input  logic [axiPkg::addrWidth-1:0]     ARADDR,
	input  logic [axiPkg::lenWidth-1:0]      ARLEN,
	input  logic                             ARVALID,
	input  logic [axiPkg::idWidth-1:0]       AWID,
	input  logic [axiPkg::addrWidth-1:0]     AWADDR,
	input  logic                             AWVALID,
	input  logic [axiPkg::dataWidth-1:0]     WDATA,
	input  logic [axiPkg::strbWidth-1:0]     WSTRB,
	input  logic                             WVALID,
	input  logic                             RREADY,
	input  logic                             BREADY,
	input  logic [axiPkg::dataWidth-1:0]     Q,
	input  logic                             VALID,
	output logic                             ARREADY,
	output logic                             AWREADY,
	output logic                             WREADY,
	output logic [axiPkg::idWidth-1:0]       RID,
	output logic [axiPkg::dataWidth-1:0]     RDATA,
	output logic [1:0]                       RRESP,
	output logic                             RLAST,
	output logic                             RVALID,
	output logic [axiPkg::idWidth-1:0]       BID,
	output logic [1:0]                       BRESP,
	output logic                             BVALID,
	output logic                             CSn,
	output logic [axiPkg::strbWidth-1:0]     WEn,
	output logic                             RASn,
	output logic                             CASn,
	output logic [dramPkg::dramAddrWidth-1:0] A,
	output logic [axiPkg::dataWidth-1:0]     D
);

	axiPkg::addrReq_t  arReq, awReq, req;
	axiPkg::wBeat_t    wBeat;
	dramPkg::dramCmd_t dramCmd;
	logic reqValid, reqIsWrite, reqDone;
	logic readActive, lastBeat, wrRespReq, beatTaken, respTaken;

	assign arReq = '{id: ARID, addr: ARADDR, len: ARLEN};
	assign awReq = '{id: AWID, addr: AWADDR, len: '0};  // Writes are single beat
	assign wBeat = '{data: WDATA, strb: WSTRB};

	assign CSn  = dramCmd.csn;
	assign RASn = dramCmd.rasn;
	assign CASn = dramCmd.casn;
	assign WEn  = dramCmd.wen;
	assign A    = dramCmd.a;
	assign D    = dramCmd.d;

	requestCapture i_capture (
		.ACLK(ACLK), .ARESETn(ARESETn), .ARVALID(ARVALID), .AWVALID(AWVALID),
		.arReq(arReq), .awReq(awReq), .reqDone(reqDone), .ARREADY(ARREADY),
		.AWREADY(AWREADY), .req(req), .reqValid(reqValid), .reqIsWrite(reqIsWrite)
	);

	dramSequencer i_sequencer (
		.ACLK(ACLK), .ARESETn(ARESETn), .req(req), .reqValid(reqValid),
		.reqIsWrite(reqIsWrite), .WVALID(WVALID), .wBeat(wBeat), .VALID(VALID),
		.beatTaken(beatTaken), .respTaken(respTaken), .WREADY(WREADY), .dramCmd(dramCmd),
		.readActive(readActive), .lastBeat(lastBeat), .wrRespReq(wrRespReq),
		.reqDone(reqDone)
	);

	responseOut i_response (
		.ACLK(ACLK), .ARESETn(ARESETn), .Q(Q), .VALID(VALID), .RREADY(RREADY),
		.BREADY(BREADY), .readActive(readActive), .lastBeat(lastBeat),
		.wrRespReq(wrRespReq), .id(req.id), .RID(RID), .RDATA(RDATA), .RRESP(RRESP),
		.RLAST(RLAST), .RVALID(RVALID), .BID(BID), .BRESP(BRESP), .BVALID(BVALID),
		.beatTaken(beatTaken), .respTaken(respTaken)
	);

endmodule

//--- hdl/responseOut.sv
`timescale 1ns/10ps

module responseOut (
	input  logic                         ACLK,
	input  logic                         ARESETn,
	input  logic [axiPkg::dataWidth-1:0] Q,
	input  logic                         VALID,
	input  logic                         RREADY,
	input  logic                         BREADY,
	input  logic                         readActive,
	input  logic                         lastBeat,
	input  logic                         wrRespReq,
	input  logic [axiPkg::idWidth-1:0]   id,
	output logic [axiPkg::idWidth-1:0]   RID,
	output logic [axiPkg::dataWidth-1:0] RDATA,
	output logic [1:0]                   RRESP,
	output logic                         RLAST,
	output logic                         RVALID,
	output logic [axiPkg::idWidth-1:0]   BID,
	output logic [1:0]                   BRESP,
	output logic                         BVALID,
	output logic                         beatTaken,
	output logic                         respTaken
);

	logic                         heldValid;
	logic [axiPkg::dataWidth-1:0] heldData;

	// Held word takes over once the first cycle was stalled
	assign RVALID = readActive && (heldValid || VALID);
	assign RDATA  = heldValid ? heldData : Q;
	assign RLAST  = RVALID && lastBeat;
	assign RID    = id;
	assign RRESP  = 2'b00;

	assign BVALID = wrRespReq;
	assign BID    = id;
	assign BRESP  = 2'b00;

	assign beatTaken = RVALID && RREADY;
	assign respTaken = BVALID && BREADY;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			heldValid <= 1'b0;
		end else if (heldValid) begin
			if (RREADY) heldValid <= 1'b0;
		end else if (readActive && VALID && !RREADY) begin
			heldValid <= 1'b1;
		end
	end

	always_ff @(posedge ACLK) begin
		if (!heldValid && VALID) heldData <= Q;
	end

endmodule

//--- hdl/dramSequencer.sv
`timescale 1ns/10ps

module dramSequencer (
	input  logic               ACLK,
	input  logic               ARESETn,
	input  axiPkg::addrReq_t   req,
	input  logic               reqValid,
	input  logic               reqIsWrite,
	input  logic               WVALID,
	input  axiPkg::wBeat_t     wBeat,
	input  logic               VALID,
	input  logic               beatTaken,
	input  logic               respTaken,
	output logic               WREADY,
	output dramPkg::dramCmd_t  dramCmd,
	output logic               readActive,
	output logic               lastBeat,
	output logic               wrRespReq,
	output logic               reqDone
);

	dramPkg::seqState_t state, nextState;

	logic [2:0] waitCnt;
	logic [2:0] waitLimit;
	logic       waitDone;
	logic       rowOpen;

	logic [dramPkg::rowWidth-1:0]      openRow;
	logic [dramPkg::rowWidth-1:0]      curRow;
	logic [dramPkg::dramAddrWidth-1:0] colAddr;
	logic [axiPkg::addrWidth-1:0]      curAddr;
	logic [axiPkg::lenWidth-1:0]       beatsLeft;
	logic [axiPkg::dataWidth-1:0]      wData;

	assign curRow  = curAddr[dramPkg::rowMsb:dramPkg::rowLsb];
	assign colAddr = dramPkg::dramAddrWidth'(curAddr[dramPkg::colMsb:dramPkg::colLsb]);

	assign lastBeat   = beatsLeft == '0;
	assign readActive = (state == dramPkg::readCmd) || (state == dramPkg::readWait);
	assign wrRespReq  = state == dramPkg::writeResp;
	assign WREADY     = state == dramPkg::writeData;
	assign reqDone    = (state == dramPkg::readWait && beatTaken && lastBeat)
		|| (state == dramPkg::writeResp && respTaken);

	always_comb begin
		case (state)
			dramPkg::prechargeWait: waitLimit = 3'(dramPkg::preWait - 1);
			dramPkg::activateWait:  waitLimit = 3'(dramPkg::actWait - 1);
			dramPkg::writeRecover:  waitLimit = 3'(dramPkg::writeRecovery - 1);
			default:                waitLimit = 3'(dramPkg::hitWait - 1);
		endcase
	end

	assign waitDone = waitCnt == waitLimit;

	always_comb begin
		nextState = state;
		case (state)
			dramPkg::idle: if (reqValid) nextState = dramPkg::decide;
			dramPkg::decide: begin
				if (!rowOpen) begin
					nextState = dramPkg::activate;
				end else if (openRow != curRow) begin
					nextState = dramPkg::precharge;
				end else begin
					nextState = dramPkg::hitDelay;
				end
			end
			dramPkg::precharge: nextState = dramPkg::prechargeWait;
			dramPkg::prechargeWait: if (waitDone) nextState = dramPkg::activate;
			dramPkg::activate: nextState = dramPkg::activateWait;
			dramPkg::activateWait, dramPkg::hitDelay: begin
				if (waitDone) nextState = reqIsWrite ? dramPkg::writeData : dramPkg::readCmd;
			end
			dramPkg::readCmd: nextState = dramPkg::readWait;
			dramPkg::readWait: begin
				// Every further beat goes back through the row check
				if (beatTaken) nextState = lastBeat ? dramPkg::idle : dramPkg::decide;
			end
			dramPkg::writeData: if (WVALID) nextState = dramPkg::writeRecover;
			dramPkg::writeRecover: if (waitDone) nextState = dramPkg::writeResp;
			dramPkg::writeResp: if (respTaken) nextState = dramPkg::idle;
			default: nextState = dramPkg::idle;
		endcase
	end

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state   <= dramPkg::idle;
			waitCnt <= '0;
			rowOpen <= 1'b0;
		end else begin
			state   <= nextState;
			waitCnt <= (nextState != state) ? 3'd0 : waitCnt + 3'd1;
			if (state == dramPkg::precharge) begin
				rowOpen <= 1'b0;
			end else if (state == dramPkg::activate) begin
				rowOpen <= 1'b1;
			end
		end
	end

	always_ff @(posedge ACLK) begin
		if (state == dramPkg::idle && reqValid) begin
			curAddr   <= req.addr;
			beatsLeft <= req.len;
		end else if (state == dramPkg::readWait && beatTaken && !lastBeat) begin
			curAddr   <= curAddr + axiPkg::addrWidth'(dramPkg::wordBytes);
			beatsLeft <= beatsLeft - axiPkg::lenWidth'(1);
		end
		if (state == dramPkg::activate) openRow <= curRow;
		if (state == dramPkg::writeData && WVALID) wData <= wBeat.data;
	end

	always_comb begin
		dramCmd = '{csn: 1'b1, rasn: 1'b1, casn: 1'b1, wen: 4'hf, a: '0, d: '0};
		case (state)
			dramPkg::precharge: begin
				dramCmd.csn  = 1'b0;
				dramCmd.rasn = 1'b0;
				dramCmd.wen  = 4'h0;
				dramCmd.a    = openRow;
			end
			dramPkg::activate: begin
				dramCmd.csn  = 1'b0;
				dramCmd.rasn = 1'b0;
				dramCmd.a    = curRow;
			end
			dramPkg::readCmd: begin
				dramCmd.csn  = 1'b0;
				dramCmd.casn = 1'b0;
				dramCmd.a    = colAddr;
			end
			dramPkg::writeData: begin
				if (WVALID) begin
					dramCmd.csn  = 1'b0;
					dramCmd.casn = 1'b0;
					dramCmd.wen  = ~wBeat.strb;  // Low bit writes that lane
					dramCmd.a    = colAddr;
					dramCmd.d    = wBeat.data;
				end
			end
			dramPkg::writeRecover: begin
				dramCmd.csn = 1'b0;
				dramCmd.a   = colAddr;
				dramCmd.d   = wData;
			end
			default: ;
		endcase
	end

endmodule

//--- hdl/requestCapture.sv
`timescale 1ns/10ps

module requestCapture (
	input  logic             ACLK,
	input  logic             ARESETn,
	input  logic             ARVALID,
	input  logic             AWVALID,
	input  axiPkg::addrReq_t arReq,
	input  axiPkg::addrReq_t awReq,
	input  logic             reqDone,
	output logic             ARREADY,
	output logic             AWREADY,
	output axiPkg::addrReq_t req,
	output logic             reqValid,
	output logic             reqIsWrite
);

	logic idleSlot;

	// Free and no handshake already in flight
	assign idleSlot = !reqValid && !ARREADY && !AWREADY;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			ARREADY  <= 1'b0;
			AWREADY  <= 1'b0;
			reqValid <= 1'b0;
		end else begin
			if (idleSlot) begin
				ARREADY <= ARVALID;  // Read wins a tie
				AWREADY <= !ARVALID && AWVALID;
			end else begin
				ARREADY <= 1'b0;
				AWREADY <= 1'b0;
			end

			if (ARREADY || AWREADY) begin
				reqValid <= 1'b1;
			end else if (reqDone) begin
				reqValid <= 1'b0;
			end
		end
	end

	// Address sampled during the ready pulse
	always_ff @(posedge ACLK) begin
		if (ARREADY) begin
			req        <= arReq;
			reqIsWrite <= 1'b0;
		end else if (AWREADY) begin
			req        <= awReq;
			reqIsWrite <= 1'b1;
		end
	end

endmodule

//--- hdl/dramPkg.sv
package dramPkg;

	// Byte address fields
	localparam int rowMsb = 22;
	localparam int rowLsb = 12;
	localparam int colMsb = 11;
	localparam int colLsb = 2;

	localparam int rowWidth      = 11;
	localparam int dramAddrWidth = 11;

	// Cycle counts
	localparam int actWait       = 5;
	localparam int preWait       = 5;
	localparam int hitWait       = 5;
	localparam int writeRecovery = 4;

	localparam int wordBytes = 4;  // Address step per beat

	// DRAM pins for one cycle, all strobes active low
	typedef struct packed {
		logic                     csn;
		logic                     rasn;
		logic                     casn;
		logic [3:0]               wen;
		logic [dramAddrWidth-1:0] a;
		logic [31:0]              d;
	} dramCmd_t;

	typedef enum logic [3:0] {
		idle,
		decide,
		precharge,
		prechargeWait,
		activate,
		activateWait,
		hitDelay,
		readCmd,
		readWait,
		writeData,
		writeRecover,
		writeResp
	} seqState_t;

endpackage

//--- hdl/axiPkg.sv
package axiPkg;

	// AXI side widths
	localparam int idWidth   = 8;
	localparam int addrWidth = 32;
	localparam int dataWidth = 32;
	localparam int lenWidth  = 8;
	localparam int strbWidth = 4;

	// One read or write address request
	typedef struct packed {
		logic [idWidth-1:0]   id;
		logic [addrWidth-1:0] addr;
		logic [lenWidth-1:0]  len;  // Beats minus one
	} addrReq_t;

	// One write data beat
	typedef struct packed {
		logic [dataWidth-1:0] data;
		logic [strbWidth-1:0] strb;
	} wBeat_t;

endpackage
